// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

  // Cache geometry
  localparam int addr_w     = 32;
  localparam int line_words = 2;
  localparam int num_sets   = 4;
  localparam int offset_w   = $clog2(line_words);
  localparam int index_w    = $clog2(num_sets);
  localparam int tag_w      = addr_w - index_w - offset_w - 2;

  localparam logic [addr_w-1:0] pc_reset = 32'h8000_0000;

  // Opcodes that hold fetch until a redirect or skip
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_branch = 7'b110_0011;
  localparam logic [6:0] op_system = 7'b111_0011;
  localparam logic [6:0] op_load   = 7'b000_0011;

  localparam logic [addr_w-1:0] inst_fence_i = 32'h0000_100f;

  typedef enum logic [1:0] {
    refill_idle,
    refill_word0,
    refill_word1
  } refill_state_e;

  typedef struct packed {
    logic              valid;
    logic [addr_w-1:0] pc;
  } fetch_req_t;

  typedef struct packed {
    logic              hit;
    logic [addr_w-1:0] inst;
  } fetch_rsp_t;

  typedef struct packed {
    logic              valid;  // Level, held until the response
    logic [addr_w-1:0] addr;
  } bus_ar_t;

  typedef struct packed {
    logic              valid;  // One-cycle pulse
    logic [addr_w-1:0] data;
  } bus_r_t;

endpackage

// ==== logic/l1i_cache.sv ====
`timescale 1ns/10ps

module l1i_cache (
  input  logic                  clk,
  input  logic                  rst,
  input  fetch_pkg::fetch_req_t req_i,
  output fetch_pkg::fetch_rsp_t rsp_o,
  input  logic                  fence_i,
  output fetch_pkg::bus_ar_t    bus_ar_o,
  input  fetch_pkg::bus_r_t     bus_r_i
);

  logic [fetch_pkg::tag_w-1:0]    req_tag;
  logic [fetch_pkg::index_w-1:0]  req_index;
  logic [fetch_pkg::offset_w-1:0] req_offset;

  logic [fetch_pkg::addr_w-1:0]   data_q [fetch_pkg::num_sets][fetch_pkg::line_words];
  logic [fetch_pkg::tag_w-1:0]    tag_q [fetch_pkg::num_sets];
  logic [fetch_pkg::num_sets-1:0] valid_q;

  fetch_pkg::refill_state_e       state_q;
  logic [fetch_pkg::tag_w-1:0]    fill_tag_q;
  logic [fetch_pkg::index_w-1:0]  fill_index_q;
  logic [fetch_pkg::offset_w-1:0] fill_word;

  logic hit;
  logic start_fill;
  logic beat_done;
  logic last_beat;

  // PC split: tag | index | word offset | byte offset
  assign req_offset = req_i.pc[fetch_pkg::offset_w+1:2];
  assign req_index  = req_i.pc[fetch_pkg::index_w+fetch_pkg::offset_w+1:fetch_pkg::offset_w+2];
  assign req_tag    = req_i.pc[fetch_pkg::addr_w-1:fetch_pkg::addr_w-fetch_pkg::tag_w];

  // No hit while a line is being filled
  assign hit = req_i.valid
               && valid_q[req_index]
               && (tag_q[req_index] == req_tag)
               && (state_q == fetch_pkg::refill_idle);

  assign rsp_o.hit  = hit;
  assign rsp_o.inst = data_q[req_index][req_offset];

  assign start_fill = req_i.valid && !hit && (state_q == fetch_pkg::refill_idle);
  assign beat_done  = bus_ar_o.valid && bus_r_i.valid;
  assign last_beat  = (state_q == fetch_pkg::refill_word1) && bus_r_i.valid;

  always_comb begin
    fill_word = '0;
    if (state_q == fetch_pkg::refill_word1) begin
      fill_word[0] = 1'b1;  // Second word of the line
    end
  end

  // Request level stays up with a fixed address until the response pulse
  assign bus_ar_o.valid = (state_q != fetch_pkg::refill_idle);
  assign bus_ar_o.addr  = {fill_tag_q, fill_index_q, fill_word, 2'b00};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= fetch_pkg::refill_idle;
      valid_q <= '0;
    end else begin
      case (state_q)
        fetch_pkg::refill_idle: begin
          if (start_fill) begin
            state_q <= fetch_pkg::refill_word0;
          end
        end
        fetch_pkg::refill_word0: begin
          if (bus_r_i.valid) begin
            state_q <= fetch_pkg::refill_word1;
          end
        end
        fetch_pkg::refill_word1: begin
          if (last_beat) begin
            state_q               <= fetch_pkg::refill_idle;
            valid_q[fill_index_q] <= 1'b1;  // Line usable only when complete
          end
        end
        default: begin
          state_q <= fetch_pkg::refill_idle;
        end
      endcase
      if (fence_i) begin
        valid_q <= '0;  // Overrides a final valid write in the same cycle
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_fill) begin
      fill_tag_q   <= req_tag;
      fill_index_q <= req_index;
    end
    if (beat_done) begin
      data_q[fill_index_q][fill_word] <= bus_r_i.data;
    end
    if (last_beat) begin
      tag_q[fill_index_q] <= fill_tag_q;
    end
  end

endmodule

// ==== logic/fetch_ctrl.sv ====
`timescale 1ns/10ps

module fetch_ctrl (
  input  logic                         clk,
  input  logic                         rst,
  output fetch_pkg::fetch_req_t        req_o,
  input  fetch_pkg::fetch_rsp_t        rsp_i,
  output logic [fetch_pkg::addr_w-1:0] pc_o,
  output logic [fetch_pkg::addr_w-1:0] inst_o,
  output logic                         inst_valid_o,
  input  logic                         inst_ready_i,
  input  logic                         redirect_i,
  input  logic                         skip_i,
  input  logic [fetch_pkg::addr_w-1:0] target_i,
  output logic                         fence_o
);

  logic [fetch_pkg::addr_w-1:0] pc_q;
  logic                         stall_q;

  logic [6:0] opcode;
  logic       is_ctrl;
  logic       is_load;
  logic       handover;
  logic       resume;

  // No lookup and no refill while waiting on the later stage
  assign req_o.valid = !stall_q;
  assign req_o.pc    = pc_q;

  assign pc_o         = pc_q;
  assign inst_o       = rsp_i.inst;
  assign inst_valid_o = rsp_i.hit && !stall_q;

  assign handover = inst_valid_o && inst_ready_i;

  assign opcode  = rsp_i.inst[6:0];
  assign is_ctrl = (opcode == fetch_pkg::op_jal)
                   || (opcode == fetch_pkg::op_jalr)
                   || (opcode == fetch_pkg::op_branch)
                   || (opcode == fetch_pkg::op_system);
  assign is_load = (opcode == fetch_pkg::op_load);

  // Redirect and skip both continue at target_i
  assign resume = redirect_i || skip_i;

  assign fence_o = handover && (rsp_i.inst == fetch_pkg::inst_fence_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= fetch_pkg::pc_reset;
      stall_q <= 1'b0;
    end else if (stall_q) begin
      if (resume) begin
        pc_q    <= target_i;
        stall_q <= 1'b0;
      end
    end else if (handover) begin
      if (is_ctrl || is_load) begin
        stall_q <= 1'b1;  // Hold PC until redirect or skip
      end else begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

endmodule

// ==== logic/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top (
  input  logic                         clk,
  input  logic                         rst,
  output fetch_pkg::bus_ar_t           bus_ar_o,
  input  fetch_pkg::bus_r_t            bus_r_i,
  output logic [fetch_pkg::addr_w-1:0] pc_o,
  output logic [fetch_pkg::addr_w-1:0] inst_o,
  output logic                         inst_valid_o,
  input  logic                         inst_ready_i,
  input  logic                         redirect_i,
  input  logic                         skip_i,
  input  logic [fetch_pkg::addr_w-1:0] target_i
);

  fetch_pkg::fetch_req_t fetch_req;
  fetch_pkg::fetch_rsp_t fetch_rsp;
  logic                  fence;

  fetch_ctrl u_fetch_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req_o        (fetch_req),
    .rsp_i        (fetch_rsp),
    .pc_o         (pc_o),
    .inst_o       (inst_o),
    .inst_valid_o (inst_valid_o),
    .inst_ready_i (inst_ready_i),
    .redirect_i   (redirect_i),
    .skip_i       (skip_i),
    .target_i     (target_i),
    .fence_o      (fence)
  );

  l1i_cache u_l1i_cache (
    .clk      (clk),
    .rst      (rst),
    .req_i    (fetch_req),
    .rsp_o    (fetch_rsp),
    .fence_i  (fence),  // FENCE.I handover strobe
    .bus_ar_o (bus_ar_o),
    .bus_r_i  (bus_r_i)
  );

endmodule

// ==== sim/imem_model.sv ====
`timescale 1ns/10ps

module imem_model (
  input  logic               clk,
  input  fetch_pkg::bus_ar_t bus_ar_i,
  output fetch_pkg::bus_r_t  bus_r_o
);

  logic [31:0] words [64];  // Word index is addr[7:2], rewritten by the testbench
  logic [31:0] lcg_state;
  logic [31:0] read_addr;
  logic        busy;
  int          delay;

  function automatic int next_delay();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return 1 + int'((lcg_state >> 16) % 4);
  endfunction

  initial begin
    lcg_state = 32'd95962;
    read_addr = '0;
    busy      = 1'b0;
    delay     = 0;
    bus_r_o   = '0;
    forever begin
      @(posedge clk);
      #1;
      bus_r_o.valid = 1'b0;  // Response is a one-cycle pulse
      if (busy) begin
        if (delay <= 1) begin
          bus_r_o.valid = 1'b1;
          bus_r_o.data  = words[read_addr[7:2]];
          busy          = 1'b0;
        end else begin
          delay = delay - 1;
        end
      end else if (bus_ar_i.valid) begin
        read_addr = bus_ar_i.addr;
        delay     = next_delay();  // 1 to 4 cycles
        busy      = 1'b1;
      end
    end
  end

endmodule

// ==== sim/tb_fetch.sv ====
`timescale 1ns/10ps

module tb_fetch;

  logic               clk;
  logic               rst;
  fetch_pkg::bus_ar_t bus_ar;
  fetch_pkg::bus_r_t  bus_r;
  logic [31:0]        pc;
  logic [31:0]        inst;
  logic               inst_valid;
  logic               inst_ready;
  logic               redirect;
  logic               skip;
  logic [31:0]        target;

  logic [31:0] rand_state;
  logic        resume_pending;  // Set by the compare process and consumed by decode
  logic        resume_redirect;
  logic [31:0] resume_target;
  int          resume_gap;
  logic [31:0] expected_pc;
  logic        waiting;
  logic        held;
  logic [31:0] held_pc;
  logic [31:0] held_inst;
  int          branch_count;
  int          idle_cycles;
  logic        fence_seen;
  logic        refetch_seen;
  logic        done;

  fetch_top DUT (
    .clk          (clk),
    .rst          (rst),
    .bus_ar_o     (bus_ar),
    .bus_r_i      (bus_r),
    .pc_o         (pc),
    .inst_o       (inst),
    .inst_valid_o (inst_valid),
    .inst_ready_i (inst_ready),
    .redirect_i   (redirect),
    .skip_i       (skip),
    .target_i     (target)
  );

  imem_model u_imem (
    .clk      (clk),
    .bus_ar_i (bus_ar),
    .bus_r_o  (bus_r)
  );

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return {17'd0, rand_state[30:16]};
  endfunction

  function automatic logic [31:0] word_addr(input int idx);
    return fetch_pkg::pc_reset + 32'(idx * 4);
  endfunction

  function automatic logic [31:0] jal_word(input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd0, fetch_pkg::op_jal};
  endfunction

  function automatic logic [31:0] jal_offset(input logic [31:0] w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  // BNE x1, x0
  function automatic logic [31:0] branch_word(input logic [31:0] off);
    return {off[12], off[10:5], 5'd0, 5'd1, 3'b001, off[4:1], off[11], fetch_pkg::op_branch};
  endfunction

  function automatic logic [31:0] branch_offset(input logic [31:0] w);
    return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] program_word(input int idx);
    logic [31:0] addr;
    addr = word_addr(idx);
    case (idx)
      5, 44, 57: return {addr[11:0], 5'd0, 3'b010, 5'd2, fetch_pkg::op_load};
      12:        return jal_word(word_addr(40) - addr);  // Into the loop
      41:        return jal_word(word_addr(43) - addr);
      43:        return branch_word(word_addr(40) - addr);
      47:        return fetch_pkg::inst_fence_i;
      48:        return jal_word(word_addr(46) - addr);
      default:   return {addr[11:0], 5'd0, 3'b000, 5'd1, 7'b001_0011};  // ADDI x1, x0, addr
    endcase
  endfunction

  // Expected instruction word from the model's current contents
  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    return u_imem.words[addr[7:2]];
  endfunction

  task automatic stop_with_failure();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    stop_with_failure();
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    stop_with_failure();
  endtask

  task automatic check_handover();
    logic [31:0] exp;
    logic [6:0]  op;
    exp = ref_word(pc);
    op  = exp[6:0];
    idle_cycles = 0;
    assert (inst == exp) else report_mismatch("instruction at pc", exp, inst);
    assert (pc == expected_pc) else report_mismatch("pc sequence", expected_pc, pc);
    if (fence_seen && pc == word_addr(46)) begin
      assert (refetch_seen) else report_error("rewritten word was served without a bus read");
    end
    if (exp == fetch_pkg::inst_fence_i) begin
      fence_seen = 1'b1;
      u_imem.words[46] = jal_word(word_addr(56) - word_addr(46));  // Exit path
    end
    done = done || (pc == word_addr(58));
    expected_pc = pc + 32'd4;
    if (op == fetch_pkg::op_jal || op == fetch_pkg::op_jalr || op == fetch_pkg::op_branch
        || op == fetch_pkg::op_system || op == fetch_pkg::op_load) begin
      resume_redirect = (op != fetch_pkg::op_load);
      resume_target   = pc + 32'd4;
      if (op == fetch_pkg::op_jal) begin
        resume_target = pc + jal_offset(exp);
      end else if (op == fetch_pkg::op_branch) begin
        resume_redirect = (branch_count < 2);  // Taken twice and then falls through
        resume_target   = resume_redirect ? pc + branch_offset(exp) : pc + 32'd4;
        branch_count++;
      end
      resume_gap     = int'(next_rand() % 4);
      resume_pending = 1'b1;
      waiting        = 1'b1;
      expected_pc    = resume_target;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Decode stand-in
  initial begin
    inst_ready = 1'b0;
    redirect   = 1'b0;
    skip       = 1'b0;
    target     = '0;
    forever begin
      @(posedge clk);
      #1;
      redirect = 1'b0;
      skip     = 1'b0;
      if (resume_pending) begin
        if (resume_gap == 0) begin
          redirect       = resume_redirect;
          skip           = !resume_redirect;
          target         = resume_target;
          resume_pending = 1'b0;
        end else begin
          resume_gap--;
        end
      end
      inst_ready = (next_rand() % 4) != 0;
    end
  end

  // Compare at the falling edge where every DUT output has settled
  always @(negedge clk) begin
    if (!rst) begin
      idle_cycles++;
      if (idle_cycles > 200) begin
        report_error("no instruction was handed over for 200 cycles");
      end
      if (held) begin
        assert (inst_valid) else report_error("inst_valid_o dropped under back-pressure");
        assert (pc == held_pc) else report_mismatch("pc under back-pressure", held_pc, pc);
        assert (inst == held_inst)
          else report_mismatch("inst under back-pressure", held_inst, inst);
      end
      if (branch_count >= 1 && pc >= word_addr(40) && pc <= word_addr(43)) begin
        assert (!bus_ar.valid) else report_error("bus read issued inside the cached loop");
      end
      if (fence_seen && bus_ar.valid && bus_ar.addr == word_addr(46)) begin
        refetch_seen = 1'b1;
      end
      if (waiting) begin
        assert (!inst_valid) else report_error("instruction offered before redirect or skip");
        waiting = !(redirect || skip);
      end
      if (inst_valid && inst_ready) begin
        check_handover();
      end
      held      = inst_valid && !inst_ready;
      held_pc   = pc;
      held_inst = inst;
    end
  end

  initial begin
    int wait_cycles;
    rst             = 1'b1;
    rand_state      = 32'd95962;
    resume_pending  = 1'b0;
    resume_redirect = 1'b0;
    resume_target   = '0;
    resume_gap      = 0;
    expected_pc     = fetch_pkg::pc_reset;
    waiting         = 1'b0;
    held            = 1'b0;
    held_pc         = '0;
    held_inst       = '0;
    branch_count    = 0;
    idle_cycles     = 0;
    fence_seen      = 1'b0;
    refetch_seen    = 1'b0;
    done            = 1'b0;
    wait_cycles     = 0;
    for (int i = 0; i < 64; i++) begin
      u_imem.words[i] = program_word(i);
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    while (!done && wait_cycles < 3000) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (!done) begin
      report_error("the last program word was never handed over");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// ==== src.f ====
logic/fetch_pkg.sv
logic/l1i_cache.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
sim/imem_model.sv
sim/tb_fetch.sv
